/* Makefile */
# Verilator build and run of the feature-window testbench.

VERILATOR ?= verilator
TOP       ?= tbFeatureWindowGen
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

# The simulation binary exits with a failing status when the run fails.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+verilog
verilog/frameCtrlPkg.sv
verilog/pixelTypesPkg.sv
verilog/paddingInserter.sv
verilog/rowBuffer.sv
verilog/windowAssembler.sv
verilog/featureWindowGen.sv
tests/tbFeatureWindowGen.sv

/* tests/tbFeatureWindowGen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "featureWindow_macros.svh"

module tbFeatureWindowGen;

    import frameCtrlPkg::*;
    import pixelTypesPkg::*;

    typedef struct {
        string name;
        int    colNum;
        int    rowNum;
        bit    padEn;
        laneT  zeroPoint;
        int    gapPct;   // Chance in percent that no input is offered in a cycle.
        int    stallPct; // Chance in percent that mReady is low in a cycle.
    } testRowT;

    logic     clk;
    logic     rstN;
    logic     start;
    frameCfgT cfg;
    pixelT    sPixel;
    logic     sValid;
    logic     sReady;
    windowT   mWindow;
    logic     mValid;
    logic     mReady;
    logic     frameDone;

    testRowT  testTable [$];
    pixelT    image [$];      // Unpadded frame in raster order.
    windowT   expWindows [$];
    integer   seed;

    featureWindowGen i_featureWindowGen (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .cfg       (cfg),
        .sPixel    (sPixel),
        .sValid    (sValid),
        .sReady    (sReady),
        .mWindow   (mWindow),
        .mValid    (mValid),
        .mReady    (mReady),
        .frameDone (frameDone)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first failure.");
    endtask

    task automatic checkWindow(input string testName, input int idx, input windowT expected,
                               input windowT actual);
        if (actual !== expected) begin
            failRun($sformatf("[ERROR] %s window %0d expected %h actual %h",
                              testName, idx, expected, actual));
        end
    endtask

    task automatic checkCount(input string testName, input string what, input int expected,
                              input int actual);
        if (actual != expected) begin
            failRun($sformatf("[ERROR] %s %s expected %0d actual %0d",
                              testName, what, expected, actual));
        end
    endtask

    task automatic checkFlag(input string testName, input string what, input logic expected,
                             input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("[ERROR] %s %s expected %b actual %b",
                              testName, what, expected, actual));
        end
    endtask

    function automatic bit chance(input int pct);
        int r;
        r = $random(seed);
        return ((r % 100 + 100) % 100) < pct;
    endfunction

    // Pixel of the padded frame at padded position (r, c).
    function automatic pixelT paddedPixel(input testRowT t, input int r, input int c);
        int padW;
        int padH;
        padW = t.colNum + 2;
        padH = t.rowNum + 2;
        if (!t.padEn) begin
            return image[r * t.colNum + c];
        end
        if (r == 0 || c == 0 || r == padH - 1 || c == padW - 1) begin
            return {`LANE_NUM{t.zeroPoint}};
        end
        return image[(r - 1) * t.colNum + (c - 1)];
    endfunction

    task automatic buildFrame(input testRowT t, input int padW, input int padH);
        windowT     w;
        logic [3:0] elem;
        image.delete();
        expWindows.delete();
        for (int k = 0; k < t.colNum * t.rowNum; k++) begin
            image.push_back(pixelT'($random(seed)));
        end
        for (int r = 0; r < padH - 2; r++) begin
            for (int c = 0; c < padW - 2; c++) begin
                for (int i = 0; i < 3; i++) begin
                    for (int j = 0; j < 3; j++) begin
                        elem    = 4'(3 * i + j); // Row-major, top-left first.
                        w[elem] = paddedPixel(t, r + i, c + j);
                    end
                end
                expWindows.push_back(w);
            end
        end
    endtask

    task automatic runFrame(input testRowT t);
        int   padW;
        int   padH;
        int   total;
        int   inIdx;
        int   outIdx;
        int   doneCount;
        int   cycles;
        int   limit;
        logic inFire;
        logic outFire;
        padW      = t.padEn ? t.colNum + 2 : t.colNum;
        padH      = t.padEn ? t.rowNum + 2 : t.rowNum;
        total     = t.colNum * t.rowNum;
        limit     = 60 * padW * padH + 200;
        inIdx     = 0;
        outIdx    = 0;
        doneCount = 0;
        cycles    = 0;
        inFire    = 1'b0;
        buildFrame(t, padW, padH);

        @(negedge clk);
        cfg.colNum    = colIdxT'(t.colNum);
        cfg.rowNum    = rowIdxT'(t.rowNum);
        cfg.padEn     = t.padEn;
        cfg.zeroPoint = t.zeroPoint;
        start         = 1'b1;

        while (outIdx < expWindows.size()) begin
            @(negedge clk);
            start = 1'b0;
            if (inFire) begin
                inIdx++;
                sValid = 1'b0;
            end
            // A pixel on offer stays put until it is taken.
            if (!sValid && inIdx < total && !chance(t.gapPct)) begin
                sValid = 1'b1;
                sPixel = image[inIdx];
            end
            mReady = !chance(t.stallPct);
            #1;
            inFire  = sValid && sReady;
            outFire = mValid && mReady;
            if (outFire) begin
                checkWindow(t.name, outIdx, expWindows[outIdx], mWindow);
                checkFlag(t.name, "frameDone", logic'(outIdx == expWindows.size() - 1),
                          frameDone);
                outIdx++;
            end else begin
                checkFlag(t.name, "frameDone without a window transfer", 1'b0, frameDone);
            end
            if (frameDone) begin
                doneCount++;
            end
            cycles++;
            if (cycles > limit) begin
                failRun($sformatf("Timeout in %s: only %0d of %0d windows arrived.",
                                  t.name, outIdx, expWindows.size()));
            end
        end

        // Any window after the last one would be a duplicate.
        for (int k = 0; k < 20; k++) begin
            @(negedge clk);
            mReady = 1'b1;
            #1;
            if (mValid) begin
                outIdx++;
            end
            if (frameDone) begin
                doneCount++;
            end
        end

        checkCount(t.name, "pixels consumed", total, inIdx);
        checkCount(t.name, "window count", (padH - 2) * (padW - 2), outIdx);
        checkCount(t.name, "frameDone pulses", 1, doneCount);
    endtask

    task automatic fillTable();
        testTable.push_back('{"unpadRaster", 5, 4, 1'b0, 8'h00, 0, 0});
        testTable.push_back('{"padBorder", 4, 3, 1'b1, 8'h80, 0, 0});
        testTable.push_back('{"padStalls", 7, 5, 1'b1, 8'h11, 30, 40});
        testTable.push_back('{"unpadGaps", 9, 6, 1'b0, 8'h5a, 35, 50});
        testTable.push_back('{"padWideRow", 20, 4, 1'b1, 8'hf0, 10, 25});
        testTable.push_back('{"padSinglePixel", 1, 1, 1'b1, 8'h7f, 20, 20});
        testTable.push_back('{"unpadMinimum", 3, 3, 1'b0, 8'h00, 50, 60});
        testTable.push_back('{"padTallFrame", 6, 12, 1'b1, 8'h03, 15, 30});
    endtask

    initial begin
        seed   = 32'hcba47eaa;
        rstN   = 1'b0;
        start  = 1'b0;
        cfg    = '0;
        sPixel = '0;
        sValid = 1'b0;
        mReady = 1'b0;
        fillTable();
        repeat (3) @(negedge clk);
        rstN = 1'b1;

        checkFlag("reset", "sReady", 1'b0, sReady);
        checkFlag("reset", "mValid", 1'b0, mValid);
        checkFlag("reset", "frameDone", 1'b0, frameDone);

        // Frames run back to back, each with its own size and padding.
        foreach (testTable[k]) begin
            runFrame(testTable[k]);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/featureWindowGen.sv */
`timescale 1ns/1ps
`default_nettype none

module featureWindowGen (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    start,
    input  frameCtrlPkg::frameCfgT  cfg,
    input  pixelTypesPkg::pixelT    sPixel,
    input  logic                    sValid,
    output logic                    sReady,
    output pixelTypesPkg::windowT   mWindow,
    output logic                    mValid,
    input  logic                    mReady,
    output logic                    frameDone
);

    import pixelTypesPkg::*;

    padBeatT   padBeat;
    logic      padValid;
    logic      padReady;
    colTripleT triple;
    logic      tripleValid;
    logic      tripleReady;

    paddingInserter i_paddingInserter (
        .clk      (clk),
        .rstN     (rstN),
        .start    (start),
        .cfg      (cfg),
        .sPixel   (sPixel),
        .sValid   (sValid),
        .sReady   (sReady),
        .padBeat  (padBeat),
        .padValid (padValid),
        .padReady (padReady)
    );

    rowBuffer i_rowBuffer (
        .clk         (clk),
        .rstN        (rstN),
        .padBeat     (padBeat),
        .padValid    (padValid),
        .padReady    (padReady),
        .triple      (triple),
        .tripleValid (tripleValid),
        .tripleReady (tripleReady)
    );

    windowAssembler i_windowAssembler (
        .clk         (clk),
        .rstN        (rstN),
        .triple      (triple),
        .tripleValid (tripleValid),
        .tripleReady (tripleReady),
        .mWindow     (mWindow),
        .mValid      (mValid),
        .mReady      (mReady),
        .frameDone   (frameDone)
    );

endmodule

`default_nettype wire

/* verilog/featureWindow_macros.svh */
`ifndef FEATURE_WINDOW_MACROS_SVH
`define FEATURE_WINDOW_MACROS_SVH

// One channel lane is a quantized 8-bit value.
`define LANE_WIDTH 8
`define LANE_NUM 4

// Line memories are this deep, so a padded row never exceeds it.
`define MAX_ROW_LEN 64

`endif

/* verilog/frameCtrlPkg.sv */
`default_nettype none

`include "featureWindow_macros.svh"

package frameCtrlPkg;

    // Row and column positions inside the padded raster.
    typedef logic [$clog2(`MAX_ROW_LEN)-1:0] colIdxT;
    typedef logic [$clog2(`MAX_ROW_LEN)-1:0] rowIdxT;

    typedef struct packed {
        colIdxT                  colNum;    // Unpadded width.
        rowIdxT                  rowNum;    // Unpadded height.
        logic                    padEn;
        logic [`LANE_WIDTH-1:0]  zeroPoint; // Same width as one lane.
    } frameCfgT;

    // Walk of the padding inserter over one padded frame.
    typedef enum logic [2:0] {
        IDLE,
        TOP,
        LEFT,
        BODY,
        RIGHT,
        BOTTOM
    } padStateT;

endpackage

`default_nettype wire

/* verilog/paddingInserter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "featureWindow_macros.svh"

module paddingInserter (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    start,
    input  frameCtrlPkg::frameCfgT  cfg,
    input  pixelTypesPkg::pixelT    sPixel,
    input  logic                    sValid,
    output logic                    sReady,
    output pixelTypesPkg::padBeatT  padBeat,
    output logic                    padValid,
    input  logic                    padReady
);

    import frameCtrlPkg::*;
    import pixelTypesPkg::*;

    padStateT state;
    padStateT nextState;
    frameCfgT cfgQ;
    frameCfgT curCfg;
    colIdxT   col;
    rowIdxT   row;
    colIdxT   lastColIdx;
    rowIdxT   lastRowIdx;
    logic     atLastCol;
    logic     atLastRow;
    logic     loadOk;
    logic     startEmit;
    logic     borderStep;
    logic     bodyStep;
    logic     emit;
    pixelT    zeroPixel;

    // While idle the live configuration decides the first beat.
    assign curCfg = (state == IDLE) ? cfg : cfgQ;

    assign lastColIdx = curCfg.padEn ? curCfg.colNum + colIdxT'(1) : curCfg.colNum - colIdxT'(1);
    assign lastRowIdx = curCfg.padEn ? curCfg.rowNum + rowIdxT'(1) : curCfg.rowNum - rowIdxT'(1);
    assign atLastCol  = (col == lastColIdx);
    assign atLastRow  = (row == lastRowIdx);
    assign zeroPixel  = {`LANE_NUM{curCfg.zeroPoint}};

    assign loadOk     = !padValid || padReady; // Output register free or draining.
    assign sReady     = (state == BODY) && loadOk;
    assign bodyStep   = sValid && sReady;
    assign borderStep = loadOk && (state inside {TOP, LEFT, RIGHT, BOTTOM});
    assign startEmit  = (state == IDLE) && start && cfg.padEn && loadOk;
    assign emit       = startEmit || borderStep || bodyStep;

    always_comb begin
        nextState = state;
        case (state)
            TOP: begin
                if (atLastCol) begin
                    nextState = LEFT;
                end
            end
            LEFT: nextState = BODY;
            BODY: begin
                if (curCfg.padEn) begin
                    if (col == lastColIdx - colIdxT'(1)) begin
                        nextState = RIGHT;
                    end
                end else if (atLastCol && atLastRow) begin
                    nextState = IDLE;
                end
            end
            RIGHT: begin
                // The row after this one is the bottom border.
                if (row == lastRowIdx - rowIdxT'(1)) begin
                    nextState = BOTTOM;
                end else begin
                    nextState = LEFT;
                end
            end
            BOTTOM: begin
                if (atLastCol) begin
                    nextState = IDLE;
                end
            end
            default: nextState = state;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
            col   <= '0;
            row   <= '0;
        end else if (state == IDLE) begin
            if (start) begin
                state <= cfg.padEn ? TOP : BODY;
                col   <= startEmit ? colIdxT'(1) : '0; // Pixel (0,0) may leave right away.
            end
        end else if (borderStep || bodyStep) begin
            state <= nextState;
            col   <= atLastCol ? '0 : col + colIdxT'(1);
            if (nextState == IDLE) begin
                row <= '0;
            end else if (atLastCol) begin
                row <= row + rowIdxT'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            cfgQ <= cfg;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            padValid <= 1'b0;
        end else if (emit) begin
            padValid <= 1'b1;
        end else if (padReady) begin
            padValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            padBeat.pixel   <= bodyStep ? sPixel : zeroPixel;
            padBeat.col     <= col;
            padBeat.row     <= row;
            padBeat.lastCol <= atLastCol;
            padBeat.lastRow <= atLastRow;
        end
    end

    // Input is only taken at an image position, never on the border.
    assert property (@(posedge clk) disable iff (!rstN)
        sReady |-> (col <= lastColIdx) && (row <= lastRowIdx) &&
                   (!cfgQ.padEn || (col != '0 && col != lastColIdx &&
                                    row != '0 && row != lastRowIdx)))
        else $error("sReady raised outside the body of the padded frame.");

    assert property (@(posedge clk) disable iff (!rstN)
        padValid && !padReady |=> padValid && $stable(padBeat))
        else $error("Padded beat changed while stalled.");

endmodule

`default_nettype wire

/* verilog/pixelTypesPkg.sv */
`default_nettype none

`include "featureWindow_macros.svh"

package pixelTypesPkg;

    import frameCtrlPkg::*;

    typedef logic [`LANE_WIDTH-1:0] laneT;
    typedef laneT [`LANE_NUM-1:0] pixelT;

    // One beat of the padded raster with its position.
    typedef struct packed {
        pixelT  pixel;
        colIdxT col;
        rowIdxT row;
        logic   lastCol;
        logic   lastRow;
    } padBeatT;

    // Vertical slice of a window, top is the oldest row.
    typedef struct packed {
        pixelT  top;
        pixelT  mid;
        pixelT  bot;
        colIdxT col;
        logic   lastCol;
        logic   lastRow;
    } colTripleT;

    // Row-major 3x3 window, element 0 is the top-left pixel.
    typedef pixelT [8:0] windowT;

endpackage

`default_nettype wire

/* verilog/rowBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "featureWindow_macros.svh"

module rowBuffer (
    input  logic                      clk,
    input  logic                      rstN,
    input  pixelTypesPkg::padBeatT    padBeat,
    input  logic                      padValid,
    output logic                      padReady,
    output pixelTypesPkg::colTripleT  triple,
    output logic                      tripleValid,
    input  logic                      tripleReady
);

    import frameCtrlPkg::*;
    import pixelTypesPkg::*;

    pixelT  olderRow [`MAX_ROW_LEN];
    pixelT  newerRow [`MAX_ROW_LEN];
    pixelT  topPix;
    pixelT  midPix;
    logic   accept;
    logic   emitTriple;
    colIdxT expCol;

    assign padReady   = !tripleValid || tripleReady;
    assign accept     = padValid && padReady;
    assign emitTriple = accept && (padBeat.row >= rowIdxT'(2)); // First two rows only fill.

    // Both rows are read at the incoming column before the write below.
    assign topPix = olderRow[padBeat.col];
    assign midPix = newerRow[padBeat.col];

    always_ff @(posedge clk) begin
        if (accept) begin
            olderRow[padBeat.col] <= midPix;
            newerRow[padBeat.col] <= padBeat.pixel;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            tripleValid <= 1'b0;
        end else if (emitTriple) begin
            tripleValid <= 1'b1;
        end else if (tripleReady) begin
            tripleValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (emitTriple) begin
            triple.top     <= topPix;
            triple.mid     <= midPix;
            triple.bot     <= padBeat.pixel;
            triple.col     <= padBeat.col;
            triple.lastCol <= padBeat.lastCol;
            triple.lastRow <= padBeat.lastRow;
        end
    end

    // Column the next accepted beat should carry.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            expCol <= '0;
        end else if (accept) begin
            expCol <= padBeat.lastCol ? '0 : padBeat.col + colIdxT'(1);
        end
    end

    // Columns run 0 up to lastCol without gaps and stay inside the line memories.
    assert property (@(posedge clk) disable iff (!rstN)
        accept |-> (int'(padBeat.col) < `MAX_ROW_LEN) && (padBeat.col == expCol))
        else $error("Padded column out of sequence or beyond the line memory.");

endmodule

`default_nettype wire

/* verilog/windowAssembler.sv */
`timescale 1ns/1ps
`default_nettype none

module windowAssembler (
    input  logic                      clk,
    input  logic                      rstN,
    input  pixelTypesPkg::colTripleT  triple,
    input  logic                      tripleValid,
    output logic                      tripleReady,
    output pixelTypesPkg::windowT     mWindow,
    output logic                      mValid,
    input  logic                      mReady,
    output logic                      frameDone
);

    import frameCtrlPkg::*;
    import pixelTypesPkg::*;

    colTripleT leftQ;
    colTripleT centerQ;
    windowT    nextWindow;
    logic      accept;
    logic      loadWindow;
    logic      lastQ;

    assign tripleReady = !mValid || mReady;
    assign accept      = tripleValid && tripleReady;
    assign loadWindow  = accept && (triple.col >= colIdxT'(2));

    // The incoming triple is the right column of the window.
    always_comb begin
        nextWindow[0] = leftQ.top;
        nextWindow[1] = centerQ.top;
        nextWindow[2] = triple.top;
        nextWindow[3] = leftQ.mid;
        nextWindow[4] = centerQ.mid;
        nextWindow[5] = triple.mid;
        nextWindow[6] = leftQ.bot;
        nextWindow[7] = centerQ.bot;
        nextWindow[8] = triple.bot;
    end

    // A new row starts at col 0, so two fresh columns are in place by col 2.
    always_ff @(posedge clk) begin
        if (accept) begin
            leftQ   <= centerQ;
            centerQ <= triple;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mValid <= 1'b0;
        end else if (loadWindow) begin
            mValid <= 1'b1;
        end else if (mReady) begin
            mValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (loadWindow) begin
            mWindow <= nextWindow;
            lastQ   <= triple.lastRow && triple.lastCol; // Bottom-right window of the frame.
        end
    end

    assign frameDone = mValid && mReady && lastQ;

    assert property (@(posedge clk) disable iff (!rstN)
        mValid && !mReady |=> mValid && $stable(mWindow))
        else $error("Output window changed while stalled.");

endmodule

`default_nettype wire
